/* audio_filter.f */
hw/audio_filter_pkg.sv
hw/sample_divider.sv
hw/adc_serial.sv
hw/fir_filter.sv
hw/dac_serial.sv
hw/audio_filter_top.sv
tb/tb_audio_filter.sv

/* hw/adc_serial.sv */
// Serial ADC frame engine
// Sends the command word, captures 12 data bits and flags overrun and framing errors
`timescale 1ns/1ns
`default_nettype none

module adc_serial import audio_filter_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         sample,
  input  wire         miso,
  output logic        mosi,
  output logic        cs_n,
  output adc_sample_t smp
);

  serial_state_e             state;
  logic [3:0]                bit_cnt;  // Bit being captured in SHIFT
  logic [FRAME_BITS-1:0]     tx_sr;    // Remaining command bits
  logic [FRAME_BITS-2:0]     rx_sr;    // First 15 captured bits
  logic                      ovr;      // Sticky overrun
  logic                      last_bit;

  assign last_bit = (state == SHIFT) && (bit_cnt == 4'(FRAME_BITS - 1));

  // ==================
  // Frame control
  // ==================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      bit_cnt   <= '0;
      cs_n      <= 1'b1;
      mosi      <= 1'b0;
      ovr       <= 1'b0;
      smp.valid <= 1'b0;
      smp.error <= '0;
      smp.data  <= '0;
    end else begin
      smp.valid <= 1'b0;
      case (state)
        IDLE: begin
          if (sample) begin
            state   <= SHIFT;
            bit_cnt <= '0;
            cs_n    <= 1'b0;
            mosi    <= ADC_CMD[FRAME_BITS-1]; // MSB goes out with cs_n
          end
        end
        SHIFT: begin
          if (sample) ovr <= 1'b1; // Pulse lost while busy
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit) begin
            state     <= IDLE;
            cs_n      <= 1'b1;
            mosi      <= 1'b0;
            smp.valid <= 1'b1;
            smp.error <= {|rx_sr[FRAME_BITS-2 -: 4], ovr | sample}; // Leading zeros, overrun
            smp.data  <= {rx_sr[10:0], miso}; // Last data bit straight from the pin
            ovr       <= 1'b0; // Reported, start over
          end else begin
            mosi <= tx_sr[FRAME_BITS-1];
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ==================
  // Shift registers
  // ==================
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      tx_sr <= {ADC_CMD[FRAME_BITS-2:0], 1'b0}; // Next bit after the MSB
    end else begin
      tx_sr <= tx_sr << 1;
      rx_sr <= {rx_sr[FRAME_BITS-3:0], miso};
    end
  end

endmodule

`default_nettype wire

/* hw/audio_filter_pkg.sv */
// Audio filter chain shared types
// Sample buses, filter kinds, converter command words and FIR coefficients
`default_nettype none

package audio_filter_pkg;

  // ==================
  // Sizes
  // ==================
  localparam int NUM_LANES  = 3;  // One lane per filter kind
  localparam int NUM_TAPS   = 4;
  localparam int FRAME_BITS = 16; // Both converters use 16-bit frames

  // Lane index and DAC select code share this encoding
  typedef enum logic [1:0] {
    LOWPASS  = 2'd0,
    HIGHPASS = 2'd1,
    BANDPASS = 2'd2
  } filter_kind_e;

  // Serial engine states, ADC and DAC alike
  typedef enum logic {
    IDLE  = 1'b0,
    SHIFT = 1'b1
  } serial_state_e;

  // ==================
  // Sample buses
  // ==================
  // ADC output, offset binary
  typedef struct packed {
    logic        valid;
    logic [1:0]  error; // [0] overrun, [1] framing
    logic [11:0] data;
  } adc_sample_t;

  // Filter lane output, two's complement
  typedef struct packed {
    logic               valid;
    logic [1:0]         error; // Copied from the ADC sample
    logic signed [23:0] data;
  } filt_out_t;

  // ==================
  // Converter words
  // ==================
  localparam logic [FRAME_BITS-1:0] ADC_CMD = 16'h8330; // Write ctrl reg, ch 0, normal mode
  localparam logic [3:0]            DAC_CMD = 4'b0011;  // Write and update prefix

  // Coefficients, row per kind, tap 0 is the newest sample
  typedef logic signed [7:0] coef_t;

  localparam coef_t COEF [NUM_LANES][NUM_TAPS] = '{
    '{ 8'sd32,  8'sd32,  8'sd32, 8'sd32 }, // LOWPASS, moving average
    '{-8'sd32,  8'sd64, -8'sd32, 8'sd0  }, // HIGHPASS, second difference
    '{ 8'sd32,  8'sd0,  -8'sd32, 8'sd0  }  // BANDPASS, x[n] - x[n-2]
  };

endpackage

`default_nettype wire

/* hw/audio_filter_top.sv */
// Audio filter chain top level
// Serial ADC into three parallel FIR lanes, one lane out to a serial DAC
`timescale 1ns/1ns
`default_nettype none

module audio_filter_top import audio_filter_pkg::*; #(
  parameter int SAMPLE_DIV = 40 // Clocks per sample, at least 20
) (
  input  wire          clk,      // Also the converters' serial clock
  input  wire          rst_n,
  input  filter_kind_e sel,      // Lane sent to the DAC
  input  wire          adc_miso,
  output logic         adc_mosi,
  output logic         adc_cs_n,
  output logic         dac_mosi,
  output logic         dac_cs_n
);

  // ==================
  // Internal buses
  // ==================
  logic        sample;                // Sample rate strobe
  adc_sample_t adc_smp;               // Fans out to every lane
  filt_out_t   lane_out [NUM_LANES];  // Indexed by filter kind

  sample_divider #(
    .SAMPLE_DIV(SAMPLE_DIV)
  ) divider (
    .clk   (clk),
    .rst_n (rst_n),
    .sample(sample)
  );

  adc_serial adc (
    .clk   (clk),
    .rst_n (rst_n),
    .sample(sample),
    .miso  (adc_miso),
    .mosi  (adc_mosi),
    .cs_n  (adc_cs_n),
    .smp   (adc_smp)
  );

  // Lane i runs filter kind i
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    fir_filter #(
      .KIND(filter_kind_e'(i))
    ) lane (
      .clk  (clk),
      .rst_n(rst_n),
      .smp  (adc_smp),
      .out  (lane_out[i])
    );
  end

  dac_serial dac (
    .clk  (clk),
    .rst_n(rst_n),
    .sel  (sel),
    .lanes(lane_out),
    .mosi (dac_mosi),
    .cs_n (dac_cs_n)
  );

endmodule

`default_nettype wire

/* hw/dac_serial.sv */
// Serial DAC frame engine
// Selects one lane, scales and saturates to 12 bits, shifts out a 16-bit frame
`timescale 1ns/1ns
`default_nettype none

module dac_serial import audio_filter_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  filter_kind_e sel,
  input  filt_out_t    lanes [NUM_LANES],
  output logic         mosi,
  output logic         cs_n
);

  serial_state_e         state;
  logic [3:0]            bit_cnt;
  logic [FRAME_BITS-1:0] tx_sr;
  filt_out_t             lane;
  logic signed [16:0]    scaled;  // data >>> 7 keeps 17 bits
  logic signed [11:0]    sat;
  logic [11:0]           code;    // Offset binary for the DAC
  logic [FRAME_BITS-1:0] frame;
  logic                  start;

  // ==================
  // Lane pick and scaling
  // ==================
  assign lane = (sel < NUM_LANES) ? lanes[sel] : '0; // Code 3 picks nothing

  assign scaled = 17'(lane.data >>> 7);

  always_comb begin
    if (scaled > 17'sd2047)        sat = 12'sd2047;
    else if (scaled < -17'sd2048)  sat = -12'sd2048;
    else                           sat = 12'(scaled);
  end

  assign code  = {~sat[11], sat[10:0]}; // Same as adding 2048
  assign frame = {DAC_CMD, code};
  assign start = (state == IDLE) && lane.valid && (lane.error == 2'b00); // Busy drops valids

  // ==================
  // Frame control
  // ==================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state   <= SHIFT;
            bit_cnt <= '0;
            cs_n    <= 1'b0;
            mosi    <= frame[FRAME_BITS-1];
          end
        end
        SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'(FRAME_BITS - 1)) begin // 16 cycles low
            state <= IDLE;
            cs_n  <= 1'b1;
            mosi  <= 1'b0;
          end else begin
            mosi <= tx_sr[FRAME_BITS-1];
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) tx_sr <= {frame[FRAME_BITS-2:0], 1'b0};
    else       tx_sr <= tx_sr << 1;
  end

endmodule

`default_nettype wire

/* hw/fir_filter.sv */
// Four-tap FIR lane
// Coefficient row picked by KIND, registered multiply-accumulate
`timescale 1ns/1ns
`default_nettype none

module fir_filter import audio_filter_pkg::*; #(
  parameter filter_kind_e KIND = LOWPASS
) (
  input  wire         clk,
  input  wire         rst_n,
  input  adc_sample_t smp,
  output filt_out_t   out
);

  // Delay line is x_cur plus three stored samples
  logic signed [12:0] x_cur;
  logic signed [12:0] hist [NUM_TAPS-1]; // hist[0] is x[n-1]
  logic signed [23:0] acc;
  logic               take;              // Good sample, enters history

  // Offset binary to signed
  assign x_cur = $signed({1'b0, smp.data}) - 13'sd2048;
  assign take  = smp.valid && (smp.error == 2'b00);

  // ==================
  // Weighted sum
  // ==================
  always_comb begin
    acc = COEF[KIND][0] * x_cur; // 24-bit signed context, no overflow
    for (int k = 1; k < NUM_TAPS; k++) begin
      acc = acc + COEF[KIND][k] * hist[k-1];
    end
  end

  // History starts from silence
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        hist[k] <= '0;
      end
    end else if (take) begin
      for (int k = NUM_TAPS - 2; k > 0; k--) begin
        hist[k] <= hist[k-1];
      end
      hist[0] <= x_cur;
    end
  end

  // Output strobe one cycle behind the ADC
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out.valid <= 1'b0;
      out.error <= '0;
      out.data  <= '0;
    end else begin
      out.valid <= smp.valid;
      if (smp.valid) begin
        out.error <= smp.error; // Passed through unchanged
        out.data  <= acc;       // Computed even for bad samples
      end
    end
  end

endmodule

`default_nettype wire

/* hw/sample_divider.sv */
// Sample rate divider
// One-cycle sample pulse every SAMPLE_DIV clocks
`timescale 1ns/1ns
`default_nettype none

module sample_divider #(
  parameter int SAMPLE_DIV = 40 // At least 20, ADC and DAC frames need the room
) (
  input  wire  clk,
  input  wire  rst_n,
  output logic sample
);

  localparam int CNT_W = $clog2(SAMPLE_DIV);

  logic [CNT_W-1:0] cnt;
  logic             wrap;

  assign wrap = (cnt == CNT_W'(SAMPLE_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt    <= '0;
      sample <= 1'b0;
    end else begin
      cnt    <= wrap ? '0 : cnt + 1'b1; // Modulo SAMPLE_DIV
      sample <= wrap;                   // First pulse SAMPLE_DIV clocks out of reset
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the audio filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --timescale 1ns/1ns \
  -f audio_filter.f \
  --top-module tb_audio_filter \
  -o tb_audio_filter \
  || { echo "Build failed"; exit 1; }

OUT=$(./obj_dir/tb_audio_filter)
echo "$OUT"

echo "$OUT" | grep -q "Result: PASSED" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

/* tb/tb_audio_filter.sv */
// Audio filter chain testbench
// ADC slave model, DAC frame capture and a reference FIR model with directed tests
`timescale 1ns/1ns
`default_nettype none

module tb_audio_filter
  import audio_filter_pkg::*;
();

  logic         clk;
  logic         rst_n;
  filter_kind_e sel;
  logic         adc_miso = 1'b0;
  logic         adc_mosi;
  logic         adc_cs_n;
  logic         dac_mosi;
  logic         dac_cs_n;

  logic [15:0]  adc_word;            // Word the ADC model returns in its next frame
  logic [15:0]  cur_word = '0;       // Shifting copy inside the frame
  logic         in_frame = 1'b0;
  int           hist [3];     // Model history, x[n-1] first
  int           errors;
  int           samples;
  logic [31:0]  rnd_state;

  audio_filter_top #(
    .SAMPLE_DIV(40)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (sel),
    .adc_miso(adc_miso),
    .adc_mosi(adc_mosi),
    .adc_cs_n(adc_cs_n),
    .dac_mosi(dac_mosi),
    .dac_cs_n(dac_cs_n)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // ==================
  // ADC slave model
  // ==================
  // Bit goes out on the falling edge, DUT samples it on the next rising edge
  always @(negedge clk) begin
    if (!adc_cs_n) begin
      if (!in_frame) cur_word = adc_word; // Latch at frame start
      adc_miso <= cur_word[15];
      cur_word = {cur_word[14:0], 1'b0};
      in_frame = 1'b1;
    end else begin
      in_frame = 1'b0;
      adc_miso <= 1'b0;
    end
  end

  // ==================
  // Reference model
  // ==================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Tap 0 is the newest sample
  function automatic int coef(input filter_kind_e kind, input int k);
    case (kind)
      LOWPASS:  return 32;
      HIGHPASS: return (k == 1) ? 64 : (k == 3) ? 0 : -32;
      default:  return (k == 0) ? 32 : (k == 2) ? -32 : 0; // Bandpass
    endcase
  endfunction

  function automatic int expect_code(input filter_kind_e kind, input int x);
    int y;
    y = coef(kind, 0) * x;
    for (int k = 1; k < 4; k++) y += coef(kind, k) * hist[k-1];
    y = y >>> 7;            // Scale to 12 bits
    if (y > 2047) y = 2047;
    else if (y < -2048) y = -2048;
    return y + 2048;        // Back to offset binary
  endfunction

  // Poll on falling edges until cs_n reaches level, bounded
  task automatic wait_cs(input bit on_dac, input logic level, input int limit, output bit seen);
    int n;
    n = 0;
    while ((on_dac ? dac_cs_n : adc_cs_n) != level && n < limit) begin
      @(negedge clk);
      n++;
    end
    seen = ((on_dac ? dac_cs_n : adc_cs_n) == level);
  endtask

  // Called on the first falling edge with cs_n low
  task automatic shift_frame(input bit on_dac, output logic [15:0] bits, output bit len_ok);
    len_ok = 1'b1;
    bits   = '0;
    for (int i = 0; i < 16; i++) begin
      bits = {bits[14:0], (on_dac ? dac_mosi : adc_mosi)};
      if ((on_dac ? dac_cs_n : adc_cs_n) != 1'b0) len_ok = 1'b0;
      @(negedge clk);
    end
    if ((on_dac ? dac_cs_n : adc_cs_n) != 1'b1) len_ok = 1'b0; // Must rise after 16
  endtask

  // Rest of one sample once the ADC frame has begun
  task automatic finish_sample(input string name, input logic [15:0] word, output int code);
    logic [15:0] bits;
    bit          ok;
    bit          good;
    int          x;
    int          exp_code;
    samples++;
    code = -1;
    shift_frame(1'b0, bits, ok);
    if (bits != ADC_CMD) begin
      errors++;
      $display("FAILED %s: ADC command expected %h, actual %h", name, ADC_CMD, bits);
    end
    if (!ok) begin
      errors++;
      $display("%s: ADC chip select was not low for exactly 16 cycles", name);
    end
    good     = (word[15:12] == 4'h0);       // Leading bits must be zero
    x        = int'(word[11:0]) - 2048;
    exp_code = expect_code(sel, x);
    if (good) begin
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = x;
    end
    wait_cs(1'b1, 1'b0, 4, ok);             // DAC starts two cycles after the ADC frame
    if (good && !ok) begin
      errors++;
      $display("%s: no DAC frame after a good sample", name);
    end else if (!good && ok) begin
      errors++;
      $display("%s: DAC frame started after a framing error", name);
    end else if (ok) begin
      shift_frame(1'b1, bits, ok);
      code = int'(bits[11:0]);
      if (bits[15:12] != DAC_CMD) begin
        errors++;
        $display("FAILED %s: DAC prefix expected %h, actual %h", name, DAC_CMD, bits[15:12]);
      end
      if (code != exp_code) begin
        errors++;
        $display("FAILED %s: DAC code expected %0d, actual %0d", name, exp_code, code);
      end
      if (!ok) begin
        errors++;
        $display("%s: DAC chip select was not low for exactly 16 cycles", name);
      end
    end
  endtask

  task automatic run_sample(input string name, input logic [15:0] word, output int code);
    bit seen;
    adc_word = word;
    wait_cs(1'b0, 1'b0, 100, seen);
    if (!seen) begin
      errors++;
      code = -1;
      $display("%s: timeout waiting for an ADC frame", name);
    end else begin
      finish_sample(name, word, code);
    end
  endtask

  // ==================
  // Directed tests
  // ==================
  task automatic test_reset_idle();
    int n;
    int code;
    adc_word = 16'h0800; // Midscale, zero after offset removal
    n = 0;
    while (adc_cs_n != 1'b0 && n < 100) begin
      if (dac_cs_n != 1'b1 || adc_mosi != 1'b0 || dac_mosi != 1'b0) begin
        errors++;
        $display("test_reset_idle: converter pins not idle %0d cycles after reset", n);
      end
      @(negedge clk);
      n++;
    end
    if (adc_cs_n != 1'b0) begin
      errors++;
      $display("test_reset_idle: timeout waiting for the first ADC frame");
    end else begin
      finish_sample("test_reset_idle", 16'h0800, code);
    end
  endtask

  task automatic test_adc_command();
    int code;
    repeat (2) run_sample("test_adc_command", 16'h0800, code);
  endtask

  task automatic test_lowpass_step();
    int code;
    sel = LOWPASS;
    for (int i = 0; i < 6; i++) begin
      run_sample("test_lowpass_step", 16'h0C00, code);
      if (i >= 3 && code != 3072) begin // Full history equals input code
        errors++;
        $display("FAILED test_lowpass_step: settled code expected 3072, actual %0d", code);
      end
    end
  endtask

  task automatic test_random_lanes();
    int code;
    for (int j = 0; j < 2; j++) begin
      if (j == 0) begin
        sel = HIGHPASS;
      end else begin
        sel = BANDPASS;
      end
      for (int i = 0; i < 20; i++) begin
        rnd_state = xorshift32(rnd_state);
        run_sample("test_random_lanes", {4'h0, rnd_state[11:0]}, code);
      end
      // Full-scale alternation pushes the output toward the code limits
      for (int i = 0; i < 4; i++) begin
        run_sample("test_random_lanes", (i % 2 == 0) ? 16'h0FFF : 16'h0000, code);
      end
    end
  endtask

  task automatic test_framing_error();
    int code;
    sel = LOWPASS;
    run_sample("test_framing_error", 16'h2ABC, code); // Nonzero leading bit
    rnd_state = xorshift32(rnd_state);
    run_sample("test_framing_error", {4'h0, rnd_state[11:0]}, code);
  endtask

  task automatic test_select_switch();
    int           code;
    filter_kind_e order [4] = '{HIGHPASS, LOWPASS, BANDPASS, HIGHPASS};
    for (int i = 0; i < 4; i++) begin
      sel = order[i];                          // Between samples
      rnd_state = xorshift32(rnd_state);
      run_sample("test_select_switch", {4'h0, rnd_state[11:0]}, code);
    end
  endtask

  initial begin
    errors    = 0;
    samples   = 0;
    rnd_state = 32'd92;
    rst_n     = 1'b0;
    sel       = LOWPASS;
    adc_word  = 16'h0800;
    hist      = '{0, 0, 0};
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_idle();
    test_adc_command();
    test_lowpass_step();
    test_random_lanes();
    test_framing_error();
    test_select_switch();
    $display("Samples: %0d, errors: %0d", samples, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
